//--- verilog/isaPkg.sv
package isaPkg;

    localparam int WordBits = 16;

    typedef logic [WordBits-1:0] word_t;

    // Opcode field values
    localparam logic [3:0] OpBne = 4'd0;
    localparam logic [3:0] OpBeq = 4'd1;
    localparam logic [3:0] OpAdi = 4'd4;
    localparam logic [3:0] OpLhi = 4'd6;
    localparam logic [3:0] OpLwd = 4'd7;
    localparam logic [3:0] OpSwd = 4'd8;
    localparam logic [3:0] OpJmp = 4'd9;
    localparam logic [3:0] OpRtype = 4'd15;

    // Function codes of the R-type group
    localparam logic [5:0] FnAdd = 6'd0;
    localparam logic [5:0] FnSub = 6'd1;
    localparam logic [5:0] FnAnd = 6'd2;
    localparam logic [5:0] FnOrr = 6'd3;
    localparam logic [5:0] FnWwd = 6'd28;
    localparam logic [5:0] FnHlt = 6'd29;

    // imm overlays {rd, func}, target overlays {rs, rt, rd, func}
    typedef struct packed {
        logic [3:0] opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        logic [5:0] func;
    } instr_t;

endpackage

//--- verilog/pipePkg.sv
package pipePkg;

    localparam int ImemDepth = 256;
    localparam int DmemDepth = 256;
    localparam int OutDepth = 4;
    localparam int ImemAddrBits = $clog2(ImemDepth);
    localparam int DmemAddrBits = $clog2(DmemDepth);
    localparam int OutPtrBits = $clog2(OutDepth);
    localparam int OutCntBits = $clog2(OutDepth + 1);

    // ALU operation select
    localparam logic [2:0] AluAdd = 3'd0;
    localparam logic [2:0] AluSub = 3'd1;
    localparam logic [2:0] AluAnd = 3'd2;
    localparam logic [2:0] AluOrr = 3'd3;
    localparam logic [2:0] AluLhi = 3'd4;

    typedef struct packed {
        logic       regWrite;
        logic       memToReg;
        logic       memRead;
        logic       memWrite;
        logic       aluSrc;
        logic       isBranch;
        logic       isJump;
        logic       isWwd;
        logic       isHlt;
        logic [2:0] aluOp;
        logic       writeRt;
    } ctrl_t;

    typedef enum logic [1:0] {FwdNone, FwdMem, FwdWb} fwdSel_t;

    typedef struct packed {
        logic [ImemAddrBits-1:0] addr;
        isaPkg::instr_t          instr;
    } load_t;

    typedef struct packed {
        logic           valid;
        isaPkg::word_t  pc;
        isaPkg::instr_t instr;
    } ifId_t;

    typedef struct packed {
        logic           valid;
        ctrl_t          ctrl;
        isaPkg::word_t  pc;
        isaPkg::instr_t instr;
        isaPkg::word_t  rsVal;
        isaPkg::word_t  rtVal;
        logic [1:0]     dst;
    } idEx_t;

    typedef struct packed {
        logic          valid;
        ctrl_t         ctrl;
        isaPkg::word_t aluOut;
        isaPkg::word_t storeVal;
        logic [1:0]    dst;
    } exMem_t;

    typedef struct packed {
        logic          valid;
        ctrl_t         ctrl;
        isaPkg::word_t aluOut;
        isaPkg::word_t loadVal;
        logic [1:0]    dst;
    } memWb_t;

endpackage

//--- verilog/progStore.sv
`timescale 1ns/100ps

module progStore (
    input  logic                             Clk,
    input  logic                             rstN,
    input  logic                             loadReq,
    output logic                             loadAck,
    input  pipePkg::load_t                   loadWord,
    input  logic [pipePkg::ImemAddrBits-1:0] fetchAddr,
    output isaPkg::instr_t                   fetchInstr
);

    isaPkg::instr_t imem [pipePkg::ImemDepth];

    logic takeWord;

    // A new word is taken once per request, while ack is still low
    assign takeWord = loadReq && !loadAck;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            loadAck <= 1'b0;
        end else if (takeWord) begin
            loadAck <= 1'b1;
        end else if (!loadReq) begin
            loadAck <= 1'b0;
        end
    end

    always_ff @(posedge Clk) begin
        if (takeWord) begin
            imem[loadWord.addr] <= loadWord.instr;
        end
    end

    // Fetch reads asynchronously
    assign fetchInstr = imem[fetchAddr];

    // Ack only answers a request that was present on the previous edge
    ackFollowsReq: assert property (
        @(posedge Clk) disable iff (!rstN)
        $rose(loadAck) |-> $past(loadReq)
    );

endmodule

//--- verilog/controlUnit.sv
`timescale 1ns/100ps

module controlUnit (
    input  isaPkg::instr_t instr,
    output pipePkg::ctrl_t ctrl
);

    always_comb begin
        ctrl = '0;
        case (instr.opcode)
            isaPkg::OpRtype: begin
                case (instr.func)
                    isaPkg::FnAdd,
                    isaPkg::FnSub,
                    isaPkg::FnAnd,
                    isaPkg::FnOrr: begin
                        // Low func bits line up with the ALU select
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp = instr.func[2:0];
                    end
                    isaPkg::FnWwd: ctrl.isWwd = 1'b1;
                    isaPkg::FnHlt: ctrl.isHlt = 1'b1;
                    default: ctrl = '0;
                endcase
            end
            isaPkg::OpAdi, isaPkg::OpLhi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.writeRt = 1'b1;
                ctrl.aluOp = (instr.opcode == isaPkg::OpLhi) ? pipePkg::AluLhi : pipePkg::AluAdd;
            end
            isaPkg::OpLwd: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.writeRt = 1'b1;
            end
            isaPkg::OpSwd: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
            end
            isaPkg::OpBne, isaPkg::OpBeq: begin
                ctrl.isBranch = 1'b1;
                ctrl.aluOp = pipePkg::AluSub;
            end
            isaPkg::OpJmp: ctrl.isJump = 1'b1;
            default: ctrl = '0;
        endcase
    end

endmodule

//--- verilog/aluUnit.sv
`timescale 1ns/100ps

module aluUnit (
    input  isaPkg::word_t opA,
    input  isaPkg::word_t opB,
    input  logic [2:0]    aluOp,
    output isaPkg::word_t result,
    output logic          equal
);

    always_comb begin
        case (aluOp)
            pipePkg::AluSub: result = opA - opB;
            pipePkg::AluAnd: result = opA & opB;
            pipePkg::AluOrr: result = opA | opB;
            // Immediate moves into the upper byte
            pipePkg::AluLhi: begin
                result = {opB[isaPkg::WordBits/2-1:0], {(isaPkg::WordBits/2){1'b0}}};
            end
            default: result = opA + opB;
        endcase
    end

    // Compare for BEQ and BNE
    assign equal = (opA == opB);

endmodule

//--- verilog/hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit (
    input  logic [1:0]       idRs,
    input  logic [1:0]       idRt,
    input  pipePkg::ctrl_t   idCtrl,
    input  logic [1:0]       exRs,
    input  logic [1:0]       exRt,
    input  logic [1:0]       exRd,
    input  pipePkg::ctrl_t   exCtrl,
    input  logic [1:0]       memRd,
    input  pipePkg::ctrl_t   memCtrl,
    input  logic [1:0]       wbRd,
    input  pipePkg::ctrl_t   wbCtrl,
    output pipePkg::fwdSel_t fwdA,
    output pipePkg::fwdSel_t fwdB,
    output logic             stall
);

    logic usesRs;
    logic usesRt;

    // Source registers the ID instruction actually reads
    assign usesRs = (idCtrl.regWrite && idCtrl.aluOp != pipePkg::AluLhi)
                  || idCtrl.memWrite || idCtrl.isBranch || idCtrl.isWwd;
    assign usesRt = (idCtrl.regWrite && !idCtrl.aluSrc) || idCtrl.memWrite || idCtrl.isBranch;

    // MEM holds the younger result, so it wins over WB
    assign fwdA = (memCtrl.regWrite && memRd == exRs) ? pipePkg::FwdMem :
                  (wbCtrl.regWrite && wbRd == exRs)   ? pipePkg::FwdWb  : pipePkg::FwdNone;
    assign fwdB = (memCtrl.regWrite && memRd == exRt) ? pipePkg::FwdMem :
                  (wbCtrl.regWrite && wbRd == exRt)   ? pipePkg::FwdWb  : pipePkg::FwdNone;

    // Load data is not ready until WB
    assign stall = exCtrl.memRead && ((usesRs && exRd == idRs) || (usesRt && exRd == idRt));

endmodule

//--- verilog/pipeCore.sv
`timescale 1ns/100ps

module pipeCore (
    input  logic                             Clk,
    input  logic                             rstN,
    input  logic                             run,
    output logic [pipePkg::ImemAddrBits-1:0] fetchAddr,
    input  isaPkg::instr_t                   fetchInstr,
    output logic                             outPush,
    output isaPkg::word_t                    outWord,
    input  logic                             outFull,
    output logic                             halted,
    output isaPkg::word_t                    numInst
);

    isaPkg::word_t pc;
    isaPkg::word_t regFile [4];
    isaPkg::word_t dataMem [pipePkg::DmemDepth];

    pipePkg::ifId_t  ifId;
    pipePkg::idEx_t  idEx;
    pipePkg::exMem_t exMem;
    pipePkg::memWb_t memWb;

    pipePkg::ctrl_t   decCtrl;
    pipePkg::ctrl_t   idCtrl;
    logic [1:0]       idDst;
    isaPkg::word_t    idRsVal;
    isaPkg::word_t    idRtVal;
    pipePkg::fwdSel_t fwdA;
    pipePkg::fwdSel_t fwdB;
    logic             stall;
    isaPkg::word_t    exRaw;
    isaPkg::word_t    exImm;
    isaPkg::word_t    exRsVal;
    isaPkg::word_t    exRtVal;
    isaPkg::word_t    aluResult;
    logic             aluEqual;
    logic             redirect;
    isaPkg::word_t    target;
    isaPkg::word_t    memLoad;
    logic             memStore;
    isaPkg::word_t    wbData;
    logic             retire;
    logic             wbWrite;
    logic             hltRetire;

    assign fetchAddr = pc[pipePkg::ImemAddrBits-1:0];

    // Decode, bubbles carry no control
    controlUnit uControl (.instr(ifId.instr), .ctrl(decCtrl));
    assign idCtrl = ifId.valid ? decCtrl : '0;
    assign idDst = idCtrl.writeRt ? ifId.instr.rt : ifId.instr.rd;

    // Register file bypass for a write in the same cycle
    assign idRsVal = (wbWrite && memWb.dst == ifId.instr.rs) ? wbData : regFile[ifId.instr.rs];
    assign idRtVal = (wbWrite && memWb.dst == ifId.instr.rt) ? wbData : regFile[ifId.instr.rt];

    hazardUnit uHazard (
        .idRs(ifId.instr.rs), .idRt(ifId.instr.rt), .idCtrl(idCtrl),
        .exRs(idEx.instr.rs), .exRt(idEx.instr.rt), .exRd(idEx.dst), .exCtrl(idEx.ctrl),
        .memRd(exMem.dst), .memCtrl(exMem.ctrl), .wbRd(memWb.dst), .wbCtrl(memWb.ctrl),
        .fwdA(fwdA), .fwdB(fwdB), .stall(stall)
    );

    // Execute
    assign exRaw = idEx.instr;
    assign exImm = {{8{exRaw[7]}}, exRaw[7:0]};
    assign exRsVal = (fwdA == pipePkg::FwdMem) ? exMem.aluOut :
                     (fwdA == pipePkg::FwdWb)  ? wbData : idEx.rsVal;
    assign exRtVal = (fwdB == pipePkg::FwdMem) ? exMem.aluOut :
                     (fwdB == pipePkg::FwdWb)  ? wbData : idEx.rtVal;

    aluUnit uAlu (
        .opA(exRsVal), .opB(idEx.ctrl.aluSrc ? exImm : exRtVal),
        .aluOp(idEx.ctrl.aluOp), .result(aluResult), .equal(aluEqual)
    );

    assign redirect = idEx.ctrl.isJump || (idEx.ctrl.isBranch
                    && ((idEx.instr.opcode == isaPkg::OpBeq) ? aluEqual : !aluEqual));
    assign target = idEx.ctrl.isJump ? {idEx.pc[15:12], exRaw[11:0]} : idEx.pc + 1'b1 + exImm;

    // Memory access and retire
    assign memLoad = dataMem[exMem.aluOut[pipePkg::DmemAddrBits-1:0]];
    assign retire = run && !outFull && memWb.valid;
    assign hltRetire = retire && memWb.ctrl.isHlt;
    assign wbWrite = retire && memWb.ctrl.regWrite;
    assign memStore = run && !outFull && exMem.ctrl.memWrite && !hltRetire;
    assign wbData = memWb.ctrl.memToReg ? memWb.loadVal : memWb.aluOut;
    assign outPush = retire && memWb.ctrl.isWwd;
    assign outWord = memWb.aluOut;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN || !run) begin
            pc <= '0;
            ifId <= '0;
            idEx <= '0;
            exMem <= '0;
            memWb <= '0;
            halted <= 1'b0;
            numInst <= '0;
        end else if (!outFull) begin
            if (retire) begin
                numInst <= numInst + 1'b1;
            end
            if (hltRetire || halted) begin
                // Younger work behind HLT is dropped
                halted <= 1'b1;
                ifId <= '0;
                idEx <= '0;
                exMem <= '0;
                memWb <= '0;
            end else begin
                memWb <= '{valid: exMem.valid, ctrl: exMem.ctrl, aluOut: exMem.aluOut,
                           loadVal: memLoad, dst: exMem.dst};
                exMem <= '{valid: idEx.valid, ctrl: idEx.ctrl,
                           aluOut: idEx.ctrl.isWwd ? exRsVal : aluResult,
                           storeVal: exRtVal, dst: idEx.dst};
                if (redirect) begin
                    pc <= target;
                    ifId <= '0;
                    idEx <= '0;
                end else if (stall) begin
                    idEx <= '0;
                end else begin
                    idEx <= '{valid: ifId.valid, ctrl: idCtrl, pc: ifId.pc, instr: ifId.instr,
                              rsVal: idRsVal, rtVal: idRtVal, dst: idDst};
                    ifId <= '{valid: 1'b1, pc: pc, instr: fetchInstr};
                    pc <= pc + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            regFile <= '{default: '0};
        end else if (wbWrite) begin
            regFile[memWb.dst] <= wbData;
        end
    end

    always_ff @(posedge Clk) begin
        if (memStore) begin
            dataMem[exMem.aluOut[pipePkg::DmemAddrBits-1:0]] <= exMem.storeVal;
        end
    end

    // Output queue never sees a push when it is full
    noPushWhenFull: assert property (
        @(posedge Clk) disable iff (!rstN)
        outFull |-> !outPush
    );

    // PC is frozen once the program has halted
    noFetchAfterHalt: assert property (
        @(posedge Clk) disable iff (!rstN)
        halted && run |=> $stable(pc)
    );

endmodule

//--- verilog/outPort.sv
`timescale 1ns/100ps

module outPort (
    input  logic          Clk,
    input  logic          rstN,
    input  logic          outPush,
    input  isaPkg::word_t outWord,
    output logic          outFull,
    output logic          outReq,
    input  logic          outAck,
    output isaPkg::word_t outData
);

    isaPkg::word_t queue [pipePkg::OutDepth];

    logic [pipePkg::OutPtrBits-1:0] head;
    logic [pipePkg::OutPtrBits-1:0] tail;
    logic [pipePkg::OutCntBits-1:0] count;
    logic                           ackWait;
    logic                           pop;

    // Request stays up until the consumer acks, then waits for ack low
    assign outReq = (count != '0) && !ackWait;
    assign pop = outReq && outAck;
    assign outFull = (count == pipePkg::OutDepth);
    assign outData = queue[head];

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            ackWait <= 1'b0;
        end else begin
            if (outPush) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            if (outPush && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !outPush) begin
                count <= count - 1'b1;
            end
            if (pop) begin
                ackWait <= 1'b1;
            end else if (!outAck) begin
                ackWait <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (outPush) begin
            queue[tail] <= outWord;
        end
    end

    // Head value must not change while it is offered
    reqHeldUntilAck: assert property (
        @(posedge Clk) disable iff (!rstN)
        outReq && !outAck |=> outReq && $stable(outData)
    );

endmodule

//--- verilog/cpuTop.sv
`timescale 1ns/100ps

module cpuTop (
    input  logic           Clk,
    input  logic           rstN,
    input  logic           run,
    input  logic           loadReq,
    output logic           loadAck,
    input  pipePkg::load_t loadWord,
    output logic           outReq,
    input  logic           outAck,
    output isaPkg::word_t  outData,
    output logic           halted,
    output isaPkg::word_t  numInst
);

    logic [pipePkg::ImemAddrBits-1:0] fetchAddr;
    isaPkg::instr_t                   fetchInstr;
    logic                             outPush;
    isaPkg::word_t                    outWord;
    logic                             outFull;

    progStore uProgStore (
        .Clk(Clk), .rstN(rstN), .loadReq(loadReq), .loadAck(loadAck),
        .loadWord(loadWord), .fetchAddr(fetchAddr), .fetchInstr(fetchInstr)
    );

    pipeCore uPipeCore (
        .Clk(Clk), .rstN(rstN), .run(run), .fetchAddr(fetchAddr), .fetchInstr(fetchInstr),
        .outPush(outPush), .outWord(outWord), .outFull(outFull),
        .halted(halted), .numInst(numInst)
    );

    outPort uOutPort (
        .Clk(Clk), .rstN(rstN), .outPush(outPush), .outWord(outWord), .outFull(outFull),
        .outReq(outReq), .outAck(outAck), .outData(outData)
    );

endmodule

//--- tb/tbClock.sv
`timescale 1ns/100ps

module tbClock (
    output logic Clk
);

    // 100 ns period
    initial begin
        Clk = 1'b0;
        forever begin
            #50 Clk = ~Clk;
        end
    end

endmodule

//--- tb/cpuRef.svh
// ISA-level model of the program held in progMem
// Fills expWords with the WWD values, returns the number of executed instructions
function automatic isaPkg::word_t refRun(input int len);
    isaPkg::word_t  regs [4];
    isaPkg::word_t  dmem [pipePkg::DmemDepth];
    isaPkg::word_t  pcNow;
    isaPkg::word_t  pcNext;
    isaPkg::word_t  imm;
    isaPkg::word_t  addr;
    isaPkg::word_t  count;
    isaPkg::instr_t ins;
    logic           done;
    regs = '{default: '0};
    dmem = '{default: '0};
    pcNow = '0;
    count = '0;
    done = 1'b0;
    expWords.delete();
    while (!done && pcNow < len && count < RunLimit) begin
        ins = progMem[pcNow[pipePkg::ImemAddrBits-1:0]];
        imm = {{8{ins.rd[1]}}, ins.rd, ins.func};
        addr = regs[ins.rs] + imm;
        pcNext = pcNow + 1'b1;
        count++;
        case (ins.opcode)
            isaPkg::OpRtype: begin
                case (ins.func)
                    isaPkg::FnAdd: regs[ins.rd] = regs[ins.rs] + regs[ins.rt];
                    isaPkg::FnSub: regs[ins.rd] = regs[ins.rs] - regs[ins.rt];
                    isaPkg::FnAnd: regs[ins.rd] = regs[ins.rs] & regs[ins.rt];
                    isaPkg::FnOrr: regs[ins.rd] = regs[ins.rs] | regs[ins.rt];
                    isaPkg::FnWwd: expWords.push_back(regs[ins.rs]);
                    isaPkg::FnHlt: done = 1'b1;
                    default: ;
                endcase
            end
            // ADI shares the rs plus imm sum with the memory address
            isaPkg::OpAdi: regs[ins.rt] = addr;
            isaPkg::OpLhi: regs[ins.rt] = {ins.rd, ins.func, 8'h00};
            isaPkg::OpLwd: regs[ins.rt] = dmem[addr[pipePkg::DmemAddrBits-1:0]];
            isaPkg::OpSwd: dmem[addr[pipePkg::DmemAddrBits-1:0]] = regs[ins.rt];
            isaPkg::OpBne: if (regs[ins.rs] != regs[ins.rt]) pcNext = pcNext + imm;
            isaPkg::OpBeq: if (regs[ins.rs] == regs[ins.rt]) pcNext = pcNext + imm;
            isaPkg::OpJmp: pcNext = {pcNow[15:12], ins.rs, ins.rt, ins.rd, ins.func};
            default: ;
        endcase
        pcNow = pcNext;
    end
    return count;
endfunction

//--- tb/cpuTb.sv
`timescale 1ns/100ps

module cpuTb;

    localparam int RunLimit = 20000;
    localparam int HandLimit = 50;
    localparam int IdleCycles = 8;

    logic           Clk;
    logic           rstN;
    logic           run;
    logic           loadReq;
    logic           loadAck;
    pipePkg::load_t loadWord;
    logic           outReq;
    logic           outAck;
    isaPkg::word_t  outData;
    logic           halted;
    isaPkg::word_t  numInst;

    isaPkg::instr_t progMem [pipePkg::ImemDepth];
    int             progLen;
    isaPkg::word_t  expWords [$];
    isaPkg::word_t  gotWords [$];
    isaPkg::word_t  rxWord;
    int             checkIdx;
    int             testErrors;
    int             testNum;
    int             passed;
    int             failed;
    integer         seed;

    tbClock uClock (.Clk(Clk));

    cpuTop u_cpuTop (
        .Clk(Clk), .rstN(rstN), .run(run), .loadReq(loadReq), .loadAck(loadAck),
        .loadWord(loadWord), .outReq(outReq), .outAck(outAck), .outData(outData),
        .halted(halted), .numInst(numInst)
    );

    `include "cpuRef.svh"

    function automatic isaPkg::instr_t rInstr(input logic [5:0] fn, input logic [1:0] rs,
                                              input logic [1:0] rt, input logic [1:0] rd);
        return {isaPkg::OpRtype, rs, rt, rd, fn};
    endfunction

    function automatic isaPkg::instr_t iInstr(input logic [3:0] op, input logic [1:0] rs,
                                              input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic put(input isaPkg::instr_t ins);
        progMem[progLen] = ins;
        progLen++;
    endtask

    task automatic stopOnTimeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("Test FAILED");
        $finish;
    endtask

    task automatic checkWord(input isaPkg::word_t got, input isaPkg::word_t exp);
        if (got !== exp) begin
            $display("error %0t: output word %0d is %h, expected %h", $time, checkIdx, got, exp);
            testErrors++;
        end
    endtask

    task automatic checkCount(input isaPkg::word_t got, input isaPkg::word_t exp);
        if (got !== exp) begin
            $display("error %0t: numInst is %0d, expected %0d", $time, got, exp);
            testErrors++;
        end
    endtask

    task automatic waitLoadAck(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(posedge Clk);
            cycles++;
            if (cycles > HandLimit) begin
                stopOnTimeout("loadAck did not follow loadReq");
            end
        end while (loadAck !== level);
    endtask

    task automatic waitReqLow();
        int cycles;
        cycles = 0;
        do begin
            @(posedge Clk);
            cycles++;
            if (cycles > HandLimit) begin
                stopOnTimeout("outReq stayed high after outAck");
            end
        end while (outReq !== 1'b0);
    endtask

    task automatic waitHalted();
        int cycles;
        cycles = 0;
        while (halted !== 1'b1) begin
            @(posedge Clk);
            cycles++;
            if (cycles > RunLimit) begin
                stopOnTimeout("halted never rose");
            end
        end
    endtask

    task automatic applyReset();
        @(posedge Clk);
        rstN <= 1'b0;
        repeat (10) @(posedge Clk);
        rstN <= 1'b1;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < progLen; i++) begin
            @(posedge Clk);
            loadWord <= '{addr: pipePkg::ImemAddrBits'(i), instr: progMem[i]};
            loadReq <= 1'b1;
            waitLoadAck(1'b1);
            loadReq <= 1'b0;
            waitLoadAck(1'b0);
        end
    endtask

    // Four-phase consumer; ends once halted and the port stays idle
    task automatic collectOutput(input int delayMax);
        int idle;
        int cycles;
        int ackDelay;
        idle = 0;
        cycles = 0;
        while (idle < IdleCycles) begin
            @(posedge Clk);
            cycles++;
            if (cycles > RunLimit) begin
                stopOnTimeout("output port still busy at the cycle limit");
            end
            if (outReq) begin
                gotWords.push_back(outData);
                ackDelay = $unsigned($random(seed)) % (delayMax + 1);
                repeat (ackDelay) @(posedge Clk);
                outAck <= 1'b1;
                waitReqLow();
                outAck <= 1'b0;
                idle = 0;
            end else if (halted) begin
                idle++;
            end
        end
    endtask

    // Words are checked in arrival order, away from the rising edge
    always @(negedge Clk) begin
        if (gotWords.size() != 0) begin
            rxWord = gotWords.pop_front();
            if (checkIdx < expWords.size()) begin
                checkWord(rxWord, expWords[checkIdx]);
            end else begin
                $display("unexpected extra output word %h at %0t", rxWord, $time);
                testErrors++;
            end
            checkIdx++;
        end
    end

    task automatic runTest(input string name, input int delayMax);
        isaPkg::word_t wantCount;
        applyReset();
        wantCount = refRun(progLen);
        testErrors = 0;
        checkIdx = 0;
        gotWords.delete();
        loadProgram();
        @(posedge Clk);
        run <= 1'b1;
        fork
            waitHalted();
            collectOutput(delayMax);
        join
        checkCount(numInst, wantCount);
        if (checkIdx != expWords.size()) begin
            $display("%0d output words received, %0d expected", checkIdx, expWords.size());
            testErrors++;
        end
        if (halted !== 1'b1) begin
            $display("halted dropped before the end of the test");
            testErrors++;
        end
        run <= 1'b0;
        testNum++;
        if (testErrors == 0) begin
            passed++;
        end else begin
            failed++;
        end
        $display("test %0d %s: %s", testNum, name, (testErrors == 0) ? "pass" : "fail");
    endtask

    task automatic buildRandom(input int count);
        int          kind;
        logic [15:0] bits;
        progLen = 0;
        for (int i = 0; i < count; i++) begin
            kind = $unsigned($random(seed)) % 7;
            bits = $random(seed);
            case (kind)
                0: put(rInstr(isaPkg::FnAdd, bits[1:0], bits[3:2], bits[5:4]));
                1: put(rInstr(isaPkg::FnSub, bits[1:0], bits[3:2], bits[5:4]));
                2: put(rInstr(isaPkg::FnAnd, bits[1:0], bits[3:2], bits[5:4]));
                3: put(rInstr(isaPkg::FnOrr, bits[1:0], bits[3:2], bits[5:4]));
                4: put(iInstr(isaPkg::OpAdi, bits[1:0], bits[3:2], bits[15:8]));
                5: put(iInstr(isaPkg::OpLhi, bits[1:0], bits[3:2], bits[15:8]));
                default: put(rInstr(isaPkg::FnWwd, bits[1:0], 2'd0, 2'd0));
            endcase
        end
        for (int r = 0; r < 4; r++) begin
            put(rInstr(isaPkg::FnWwd, 2'(r), 2'd0, 2'd0));
        end
        put(rInstr(isaPkg::FnHlt, 2'd0, 2'd0, 2'd0));
    endtask

    initial begin
        rstN = 1'b0;
        run = 1'b0;
        loadReq = 1'b0;
        loadWord = '0;
        outAck = 1'b0;
        seed = 11851;
        testNum = 0;
        passed = 0;
        failed = 0;
        checkIdx = 0;

        // Back-to-back ALU dependencies
        progLen = 0;
        put(iInstr(isaPkg::OpAdi, 2'd0, 2'd1, 8'd5));
        put(iInstr(isaPkg::OpAdi, 2'd1, 2'd2, 8'd3));
        put(rInstr(isaPkg::FnAdd, 2'd1, 2'd2, 2'd3));
        put(rInstr(isaPkg::FnWwd, 2'd3, 2'd0, 2'd0));
        put(rInstr(isaPkg::FnSub, 2'd3, 2'd1, 2'd0));
        put(rInstr(isaPkg::FnAnd, 2'd0, 2'd3, 2'd1));
        put(rInstr(isaPkg::FnOrr, 2'd1, 2'd0, 2'd2));
        put(iInstr(isaPkg::OpLhi, 2'd0, 2'd3, 8'h7f));
        put(iInstr(isaPkg::OpAdi, 2'd3, 2'd3, 8'hfe));
        for (int r = 0; r < 4; r++) begin
            put(rInstr(isaPkg::FnWwd, 2'(r), 2'd0, 2'd0));
        end
        put(rInstr(isaPkg::FnHlt, 2'd0, 2'd0, 2'd0));
        runTest("ALU forwarding chain", 0);

        // Store, load and immediate use
        progLen = 0;
        put(iInstr(isaPkg::OpAdi, 2'd0, 2'd1, 8'd10));
        put(iInstr(isaPkg::OpLhi, 2'd0, 2'd2, 8'h12));
        put(iInstr(isaPkg::OpAdi, 2'd2, 2'd2, 8'h34));
        put(iInstr(isaPkg::OpSwd, 2'd1, 2'd2, 8'd3));
        put(iInstr(isaPkg::OpLwd, 2'd1, 2'd3, 8'd3));
        put(rInstr(isaPkg::FnAdd, 2'd3, 2'd1, 2'd0));
        put(rInstr(isaPkg::FnWwd, 2'd0, 2'd0, 2'd0));
        put(iInstr(isaPkg::OpSwd, 2'd1, 2'd0, 8'hff));
        put(iInstr(isaPkg::OpLwd, 2'd1, 2'd2, 8'hff));
        put(rInstr(isaPkg::FnWwd, 2'd2, 2'd0, 2'd0));
        put(rInstr(isaPkg::FnHlt, 2'd0, 2'd0, 2'd0));
        runTest("load-use stall", 2);

        // Taken and not-taken branches, jump and a backward loop
        progLen = 0;
        put(iInstr(isaPkg::OpAdi, 2'd0, 2'd1, 8'd1));
        put(iInstr(isaPkg::OpAdi, 2'd0, 2'd2, 8'd1));
        put(iInstr(isaPkg::OpBeq, 2'd1, 2'd2, 8'd2));
        put(rInstr(isaPkg::FnWwd, 2'd1, 2'd0, 2'd0));
        put(rInstr(isaPkg::FnWwd, 2'd2, 2'd0, 2'd0));
        put(iInstr(isaPkg::OpBne, 2'd1, 2'd2, 8'd1));
        put(rInstr(isaPkg::FnWwd, 2'd1, 2'd0, 2'd0));
        put(iInstr(isaPkg::OpAdi, 2'd2, 2'd2, 8'd1));
        put(iInstr(isaPkg::OpBne, 2'd1, 2'd2, 8'd1));
        put(rInstr(isaPkg::FnWwd, 2'd2, 2'd0, 2'd0));
        put(iInstr(isaPkg::OpBeq, 2'd1, 2'd2, 8'd1));
        put({isaPkg::OpJmp, 12'd14});
        put(rInstr(isaPkg::FnWwd, 2'd0, 2'd0, 2'd0));
        put(rInstr(isaPkg::FnWwd, 2'd0, 2'd0, 2'd0));
        put(rInstr(isaPkg::FnWwd, 2'd2, 2'd0, 2'd0));
        put(iInstr(isaPkg::OpAdi, 2'd0, 2'd3, 8'd3));
        put(iInstr(isaPkg::OpAdi, 2'd3, 2'd3, 8'hff));
        put(rInstr(isaPkg::FnWwd, 2'd3, 2'd0, 2'd0));
        put(iInstr(isaPkg::OpBne, 2'd3, 2'd0, 8'hfd));
        put(rInstr(isaPkg::FnHlt, 2'd0, 2'd0, 2'd0));
        runTest("branches and jump", 1);

        // Output bursts against a slow consumer
        progLen = 0;
        put(iInstr(isaPkg::OpAdi, 2'd0, 2'd1, 8'd1));
        for (int i = 0; i < 12; i++) begin
            put(rInstr(isaPkg::FnWwd, 2'd1, 2'd0, 2'd0));
            put(iInstr(isaPkg::OpAdi, 2'd1, 2'd1, 8'd7));
            put(rInstr(isaPkg::FnWwd, 2'd1, 2'd0, 2'd0));
        end
        put(rInstr(isaPkg::FnHlt, 2'd0, 2'd0, 2'd0));
        runTest("output backpressure", 30);

        buildRandom(40);
        runTest("random ALU program", 4);

        $display("%0d tests passed, %0d tests failed", passed, failed);
        if (failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+tb
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/progStore.sv
verilog/controlUnit.sv
verilog/aluUnit.sv
verilog/hazardUnit.sv
verilog/pipeCore.sv
verilog/outPort.sv
verilog/cpuTop.sv
tb/tbClock.sv
tb/cpuTb.sv
